// File: filelist.f
rtl/accel_pkg.sv
rtl/weight_bus_if.sv
rtl/glb_sram.sv
rtl/weight_load_ctrl.sv
rtl/pe_row.sv
rtl/psum_collector.sv
rtl/pe_array_top.sv
tb/tb_pe_array_top.sv

// File: rtl/accel_pkg.sv
// accelerator shared types
`default_nettype none

package accel_pkg;

    localparam int WEIGHT_W   = 8;   // weight / activation width
    localparam int PSUM_W     = 20;  // holds 16 products of two int8 values
    localparam int GLB_WORD_W = 32;  // four weights per GLB word
    localparam int GLB_ADDR_W = 12;  // byte address into the GLB

    typedef enum logic [1:0] {
        LAYER_CONV   = 2'b00,  // full matrix, row major
        LAYER_DWCONV = 2'b01,  // diagonal only
        LAYER_FC     = 2'b10,  // full matrix, row major
        LAYER_POOL   = 2'b11   // no weights
    } layer_type_t;

    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [PSUM_W-1:0]   psum_t;

    // one GLB word, either raw or split into bytes; byte 0 sits in bits 7..0
    typedef union packed {
        logic [GLB_WORD_W-1:0] word;   // host write / storage view
        weight_t [3:0]         bytes;  // loader byte select view
    } glb_word_u;

    // number of weights a layer pulls out of the GLB
    function automatic int unsigned weight_count(input layer_type_t lt,
                                                 input int unsigned rows,
                                                 input int unsigned cols);
        int unsigned n;
        case (lt)
            LAYER_CONV,
            LAYER_FC:     n = rows * cols;
            LAYER_DWCONV: n = rows;
            default:      n = 0;  // pool
        endcase
        return n;
    endfunction

    // index width for a count of n, never below one bit
    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

`default_nettype wire

// File: rtl/glb_sram.sv
// global weight buffer
`timescale 1ns/1ps
`default_nettype none

module glb_sram #(
    parameter int DEPTH_WORDS = 1024
) (
    input  wire logic                           clk,
    // host side
    input  wire logic                           wr_en_i,
    input  wire logic [$clog2(DEPTH_WORDS)-1:0] wr_addr_i,    // word index
    input  wire accel_pkg::glb_word_u           wr_data_i,
    // loader side
    input  wire logic                           rd_en_i,
    input  wire logic [$clog2(DEPTH_WORDS)-1:0] rd_addr_i,    // word index
    output      accel_pkg::glb_word_u           rd_data_o     // valid one cycle after rd_en_i
);
    import accel_pkg::*;

    glb_word_u mem [DEPTH_WORDS];  // word storage, no reset

    // host write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;  // whole word at once
        end
    end

    // registered read gives the fixed one-cycle latency
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];  // holds last word when idle
        end
    end

endmodule

`default_nettype wire

// File: rtl/pe_array_top.sv
// pe array top level
`timescale 1ns/1ps
`default_nettype none

module pe_array_top #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    // host GLB write
    input  wire logic                                glb_wr_en_i,
    input  wire logic [accel_pkg::GLB_ADDR_W-3:0]    glb_wr_addr_i,   // word index
    input  wire logic [accel_pkg::GLB_WORD_W-1:0]    glb_wr_data_i,
    // weight load
    input  wire logic                                load_i,
    input  wire accel_pkg::layer_type_t              layer_type_i,
    input  wire logic [accel_pkg::GLB_ADDR_W-1:0]    weight_base_addr_i,  // byte address
    output      logic                                load_done_o,
    // compute
    input  wire logic                                act_valid_i,
    input  wire accel_pkg::weight_t [COLS-1:0]       act_vec_i,
    input  wire logic                                relu_en_i,
    output      logic                                out_valid_o,
    output      accel_pkg::psum_t [ROWS-1:0]         out_vec_o
);
    import accel_pkg::*;

    localparam int DEPTH_WORDS = 1 << (GLB_ADDR_W - 2);  // whole byte space

    logic                  glb_rd_en;
    logic [GLB_ADDR_W-3:0] glb_rd_addr;
    glb_word_u             glb_rd_data;
    weight_t               act_row [COLS];  // unpacked broadcast to the rows
    psum_t                 row_psum [ROWS];
    logic                  row_valid [ROWS];

    weight_bus_if #(.ROWS(ROWS), .COLS(COLS)) wbus ();

    glb_sram #(.DEPTH_WORDS(DEPTH_WORDS)) u_glb (
        .clk       (clk),
        .wr_en_i   (glb_wr_en_i),
        .wr_addr_i (glb_wr_addr_i),
        .wr_data_i (glb_wr_data_i),
        .rd_en_i   (glb_rd_en),
        .rd_addr_i (glb_rd_addr),
        .rd_data_o (glb_rd_data)
    );

    weight_load_ctrl #(.ROWS(ROWS), .COLS(COLS)) u_loader (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_i        (load_i),
        .layer_type_i  (layer_type_i),
        .base_addr_i   (weight_base_addr_i),
        .glb_rd_en_o   (glb_rd_en),
        .glb_rd_addr_o (glb_rd_addr),
        .glb_rd_data_i (glb_rd_data),
        .wbus          (wbus.master),
        .load_done_o   (load_done_o)
    );

    for (genvar c = 0; c < COLS; c++) begin : g_act
        assign act_row[c] = act_vec_i[c];  // packed port to row input
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        pe_row #(.ROW_IDX(r), .COLS(COLS)) u_row (
            .clk          (clk),
            .rst_n        (rst_n),
            .wbus         (wbus.slave),
            .act_valid_i  (act_valid_i),
            .act_vec_i    (act_row),
            .psum_o       (row_psum[r]),
            .psum_valid_o (row_valid[r])
        );
    end

    // all rows share one timing, row 0 speaks for them
    psum_collector #(.ROWS(ROWS)) u_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .psum_i       (row_psum),
        .psum_valid_i (row_valid[0]),
        .relu_en_i    (relu_en_i),
        .out_vec_o    (out_vec_o),
        .out_valid_o  (out_valid_o)
    );

endmodule

`default_nettype wire

// File: rtl/pe_row.sv
// processing element row
`timescale 1ns/1ps
`default_nettype none

module pe_row #(
    parameter int ROW_IDX = 0,
    parameter int COLS    = 4
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    weight_bus_if.slave            wbus,
    input  wire logic              act_valid_i,          // activation strobe
    input  wire accel_pkg::weight_t act_vec_i [COLS],    // broadcast activations
    output      accel_pkg::psum_t   psum_o,              // dot product, one cycle later
    output      logic              psum_valid_o
);
    import accel_pkg::*;

    weight_t w [COLS];  // stationary weights of this row
    psum_t   dot;       // combinational sum of products
    logic    hit;       // bus write addressed to this row

    assign hit = wbus.wr_en && (int'(wbus.wr_row) == ROW_IDX);

    // weight registers, zero after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < COLS; c++) begin
                w[c] <= '0;
            end
        end else if (hit) begin
            w[wbus.wr_col] <= wbus.wr_data;  // one pe per strobe
        end
    end

    // signed multiply-accumulate across the row
    always_comb begin
        dot = '0;
        for (int c = 0; c < COLS; c++) begin
            dot = dot + psum_t'(w[c]) * psum_t'(act_vec_i[c]);  // sign extended
        end
    end

    always_ff @(posedge clk) begin
        if (act_valid_i) begin
            psum_o <= dot;  // payload, no reset
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_valid_o <= 1'b0;
        end else begin
            psum_valid_o <= act_valid_i;  // single-cycle pulse per vector
        end
    end

    // the loader must never address a column past the row
    a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
        hit |-> (int'(wbus.wr_col) < COLS));

endmodule

`default_nettype wire

// File: rtl/psum_collector.sv
// partial sum collector
`timescale 1ns/1ps
`default_nettype none

module psum_collector #(
    parameter int ROWS = 4
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire accel_pkg::psum_t             psum_i [ROWS],  // one sum per row
    input  wire logic                         psum_valid_i,   // shared row timing
    input  wire logic                         relu_en_i,      // given with the activation vector
    output      accel_pkg::psum_t [ROWS-1:0]  out_vec_o,
    output      logic                         out_valid_o
);
    import accel_pkg::*;

    logic relu_q;  // relu flag aligned with the row sums

    // relu_en_i arrives with act_valid one cycle before the psums
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            relu_q      <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            relu_q      <= relu_en_i;
            out_valid_o <= psum_valid_i;  // pulse follows each row valid
        end
    end

    // capture and clamp
    always_ff @(posedge clk) begin
        if (psum_valid_i) begin
            for (int r = 0; r < ROWS; r++) begin
                if (relu_q && psum_i[r][PSUM_W-1]) begin
                    out_vec_o[r] <= '0;  // negative clamped
                end else begin
                    out_vec_o[r] <= psum_i[r];
                end
            end
        end
    end

    // a vector sent with relu set never comes out negative
    for (genvar r = 0; r < ROWS; r++) begin : g_relu_chk
        a_relu_clamp: assert property (@(posedge clk) disable iff (!rst_n)
            (out_valid_o && $past(relu_en_i, 2)) |-> !out_vec_o[r][PSUM_W-1]);
    end

endmodule

`default_nettype wire

// File: rtl/weight_bus_if.sv
// weight write bus
`timescale 1ns/1ps
`default_nettype none

interface weight_bus_if #(
    parameter int ROWS = 4,
    parameter int COLS = 4
);
    import accel_pkg::*;

    logic                     wr_en;    // single-cycle write strobe
    logic [idx_w(ROWS)-1:0]   wr_row;   // target pe row
    logic [idx_w(COLS)-1:0]   wr_col;   // target column within the row
    weight_t                  wr_data;  // weight byte

    modport master (output wr_en, output wr_row, output wr_col, output wr_data);
    modport slave  (input  wr_en, input  wr_row, input  wr_col, input  wr_data);

endinterface

`default_nettype wire

// File: rtl/weight_load_ctrl.sv
// weight load controller
`timescale 1ns/1ps
`default_nettype none

module weight_load_ctrl #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                load_i,         // held high through loading
    input  wire accel_pkg::layer_type_t              layer_type_i,
    input  wire logic [accel_pkg::GLB_ADDR_W-1:0]    base_addr_i,    // byte address of any alignment
    output      logic                                glb_rd_en_o,
    output      logic [accel_pkg::GLB_ADDR_W-3:0]    glb_rd_addr_o,  // word address
    input  wire accel_pkg::glb_word_u                glb_rd_data_i,
    weight_bus_if.master                             wbus,
    output      logic                                load_done_o     // one-cycle pulse at N+2
);
    import accel_pkg::*;

    localparam int ROW_W = idx_w(ROWS);
    localparam int COL_W = idx_w(COLS);
    localparam int CNT_W = $clog2(ROWS * COLS + 2);  // counts up to N+1

    logic [CNT_W-1:0]      cnt;        // weights issued so far
    logic [CNT_W-1:0]      n_wt;       // weights for this layer
    logic                  issue;      // read goes out this cycle
    logic                  rd_en_q;    // read presented to GLB in stage 1
    logic                  wr_en_q;    // write strobe in stage 2
    logic                  fin_q;      // counter hit N
    logic                  done_q;
    logic [GLB_ADDR_W-1:0] rd_byte_q;  // byte address of stage 1 read
    logic [1:0]            off_q;      // byte lane aligned with GLB data
    logic [ROW_W-1:0]      tgt_row;
    logic [COL_W-1:0]      tgt_col;
    logic [ROW_W-1:0]      s1_row;     // target follows the read
    logic [ROW_W-1:0]      s2_row;
    logic [COL_W-1:0]      s1_col;
    logic [COL_W-1:0]      s2_col;

    assign n_wt  = CNT_W'(weight_count(layer_type_i, ROWS, COLS));
    assign issue = load_i && (cnt < n_wt);

    // placement of weight cnt in the array
    always_comb begin
        if (layer_type_i == LAYER_DWCONV) begin
            tgt_row = ROW_W'(cnt);  // diagonal
            tgt_col = COL_W'(cnt);
        end else begin
            tgt_row = ROW_W'(cnt / CNT_W'(COLS));  // row major
            tgt_col = COL_W'(cnt % CNT_W'(COLS));
        end
    end

    // control pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            rd_en_q <= 1'b0;
            wr_en_q <= 1'b0;
            fin_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            if (!load_i) begin
                cnt <= '0;  // dropping load restarts the walk
            end else if (cnt <= n_wt) begin
                cnt <= cnt + 1'b1;  // parks at N+1 so done fires once
            end
            rd_en_q <= issue;
            wr_en_q <= rd_en_q && load_i;  // no strobes once load falls
            fin_q   <= load_i && (cnt == n_wt);
            done_q  <= fin_q && load_i;
        end
    end

    // address and target pipeline
    always_ff @(posedge clk) begin
        if (issue) begin
            rd_byte_q <= base_addr_i + GLB_ADDR_W'(cnt);
            s1_row    <= tgt_row;
            s1_col    <= tgt_col;
        end
        off_q  <= rd_byte_q[1:0];  // lines up with rd_data one cycle later
        s2_row <= s1_row;
        s2_col <= s1_col;
    end

    assign glb_rd_en_o   = rd_en_q;
    assign glb_rd_addr_o = rd_byte_q[GLB_ADDR_W-1:2];  // drop byte lane bits
    assign load_done_o   = done_q;

    assign wbus.wr_en   = wr_en_q;
    assign wbus.wr_row  = s2_row;
    assign wbus.wr_col  = s2_col;
    assign wbus.wr_data = glb_rd_data_i.bytes[off_q];  // lane pick through the union

    // done only once load stayed high for the whole walk
    a_done_after_walk: assert property (@(posedge clk) disable iff (!rst_n)
        load_done_o |-> (cnt == n_wt + 1'b1));

    a_row_range: assert property (@(posedge clk) disable iff (!rst_n)
        wbus.wr_en |-> (int'(wbus.wr_row) < ROWS));

    // diagonal placement needs a square array
    a_dw_square: assert property (@(posedge clk) disable iff (!rst_n)
        (load_i && layer_type_i == LAYER_DWCONV) |-> (ROWS == COLS));

endmodule

`default_nettype wire

// File: tb/tb_pe_array_top.sv
// pe array testbench
`timescale 1ns/1ps
`default_nettype none

module tb_pe_array_top;
    import accel_pkg::*;

    localparam int ROWS      = 4;
    localparam int COLS      = 4;
    localparam int GLB_WORDS = 32;   // words filled by the host
    localparam int TIMEOUT   = 100;  // cycles allowed for any wait
    localparam int BURST     = 4;    // back-to-back vectors

    typedef psum_t   [ROWS-1:0] psum_vec_t;
    typedef weight_t [COLS-1:0] act_vec_t;

    logic                    clk;
    logic                    rst_n;
    logic                    glb_wr_en_i;
    logic [GLB_ADDR_W-3:0]   glb_wr_addr_i;
    logic [GLB_WORD_W-1:0]   glb_wr_data_i;
    logic                    load_i;
    layer_type_t             layer_type_i;
    logic [GLB_ADDR_W-1:0]   weight_base_addr_i;
    logic                    load_done_o;
    logic                    act_valid_i;
    act_vec_t                act_vec_i;
    logic                    relu_en_i;
    logic                    out_valid_o;
    psum_vec_t               out_vec_o;

    logic [7:0]  glb_bytes [GLB_WORDS*4];  // byte image of the GLB
    weight_t     wmodel [ROWS][COLS];      // expected PE weights
    int          errors;
    act_vec_t    act;

    pe_array_top #(.ROWS(ROWS), .COLS(COLS)) uut (
        .clk                (clk),
        .rst_n              (rst_n),
        .glb_wr_en_i        (glb_wr_en_i),
        .glb_wr_addr_i      (glb_wr_addr_i),
        .glb_wr_data_i      (glb_wr_data_i),
        .load_i             (load_i),
        .layer_type_i       (layer_type_i),
        .weight_base_addr_i (weight_base_addr_i),
        .load_done_o        (load_done_o),
        .act_valid_i        (act_valid_i),
        .act_vec_i          (act_vec_i),
        .relu_en_i          (relu_en_i),
        .out_valid_o        (out_valid_o),
        .out_vec_o          (out_vec_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // outputs are sampled and inputs driven 2 ns past the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // weights a layer pulls by layer type
    function automatic int weights_for_layer(input layer_type_t lt);
        case (lt)
            LAYER_CONV, LAYER_FC: return ROWS * COLS;
            LAYER_DWCONV:         return ROWS;
            default:              return 0;
        endcase
    endfunction

    function automatic act_vec_t random_act();
        act_vec_t a;
        for (int c = 0; c < COLS; c++) begin
            a[c] = weight_t'($urandom);  // full signed byte range
        end
        return a;
    endfunction

    // dot product per row with optional clamp of negatives
    function automatic psum_vec_t expected_vec(input act_vec_t a, input logic relu);
        psum_vec_t v;
        int        acc;
        for (int r = 0; r < ROWS; r++) begin
            acc = 0;
            for (int c = 0; c < COLS; c++) begin
                acc += int'($signed(wmodel[r][c])) * int'($signed(a[c]));
            end
            if (relu && acc < 0) begin
                acc = 0;
            end
            v[r] = psum_t'(acc);
        end
        return v;
    endfunction

    task automatic check_psum_vec(input psum_vec_t got, input psum_vec_t exp, input string what);
        for (int r = 0; r < ROWS; r++) begin
            if (got[r] !== exp[r]) begin
                $display("ERR at %0t: %s row %0d got %0d expected %0d",
                         $time, what, r, $signed(got[r]), $signed(exp[r]));
                errors++;
            end
        end
    endtask

    task automatic check_done(input layer_type_t lt, input int cyc);
        int exp;
        exp = weights_for_layer(lt) + 2;  // N+2 after load rises
        if (cyc != exp) begin
            $display("ERR at %0t: layer %0d done in cycle %0d expected %0d",
                     $time, lt, cyc, exp);
            errors++;
        end
    endtask

    task automatic write_glb_word(input int waddr, input logic [31:0] data);
        glb_wr_en_i   = 1'b1;
        glb_wr_addr_i = waddr[GLB_ADDR_W-3:0];
        glb_wr_data_i = data;
        for (int b = 0; b < 4; b++) begin
            glb_bytes[waddr*4 + b] = data[8*b +: 8];  // byte 0 in the low bits
        end
        next_cycle();
        glb_wr_en_i = 1'b0;
    endtask

    task automatic load_layer(input layer_type_t lt, input int base);
        int cyc;
        int k;
        layer_type_i       = lt;
        weight_base_addr_i = GLB_ADDR_W'(base);
        load_i             = 1'b1;  // cycle 0
        cyc = 0;
        do begin
            next_cycle();
            cyc++;
        end while (!load_done_o && cyc < TIMEOUT);
        if (!load_done_o) begin
            $display("timeout: load_done_o never rose for layer %0d", lt);
            errors++;
        end else begin
            check_done(lt, cyc);
        end
        load_i = 1'b0;
        next_cycle();
        if (load_done_o) begin
            $display("ERR at %0t: load_done_o high for more than one cycle", $time);
            errors++;
        end
        // mirror the weight placement
        for (k = 0; k < weights_for_layer(lt); k++) begin
            if (lt == LAYER_DWCONV) begin
                wmodel[k][k] = weight_t'(glb_bytes[base + k]);
            end else begin
                wmodel[k / COLS][k % COLS] = weight_t'(glb_bytes[base + k]);
            end
        end
    endtask

    // one vector in then wait for its result and compare
    task automatic run_vector(input act_vec_t a, input logic relu, input string what);
        int lat;
        act_valid_i = 1'b1;
        act_vec_i   = a;
        relu_en_i   = relu;
        next_cycle();
        act_valid_i = 1'b0;
        lat = 1;
        while (!out_valid_o && lat < TIMEOUT) begin
            next_cycle();
            lat++;
        end
        if (!out_valid_o) begin
            $display("timeout: out_valid_o never rose for %s", what);
            errors++;
        end else begin
            if (lat != 2) begin
                $display("ERR at %0t: %s result after %0d cycles expected 2",
                         $time, what, lat);
                errors++;
            end
            check_psum_vec(out_vec_o, expected_vec(a, relu), what);
        end
    endtask

    // vectors on consecutive cycles with relu toggling
    task automatic run_burst();
        act_vec_t  acts [BURST];
        logic      relus [BURST];
        psum_vec_t exps [BURST];
        for (int i = 0; i < BURST; i++) begin
            acts[i]  = random_act();
            relus[i] = i[0];
            exps[i]  = expected_vec(acts[i], relus[i]);
        end
        for (int i = 0; i <= BURST; i++) begin
            act_valid_i = (i < BURST);
            if (i < BURST) begin
                act_vec_i = acts[i];
                relu_en_i = relus[i];
            end
            next_cycle();
            if (i >= 1) begin  // vector i-1 lands two cycles after entry
                if (!out_valid_o) begin
                    $display("ERR at %0t: burst vector %0d has no out_valid_o", $time, i - 1);
                    errors++;
                end
                check_psum_vec(out_vec_o, exps[i-1], "burst");
            end
        end
        next_cycle();
        if (out_valid_o) begin
            $display("ERR at %0t: out_valid_o high after the burst ended", $time);
            errors++;
        end
    endtask

    initial begin
        void'($urandom(32'h53af));  // single seed for the run
        errors             = 0;
        rst_n              = 1'b0;
        glb_wr_en_i        = 1'b0;
        glb_wr_addr_i      = '0;
        glb_wr_data_i      = '0;
        load_i             = 1'b0;
        layer_type_i       = LAYER_CONV;
        weight_base_addr_i = '0;
        act_valid_i        = 1'b0;
        act_vec_i          = '0;
        relu_en_i          = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                wmodel[r][c] = '0;  // PEs come out of reset empty
            end
        end
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        if (load_done_o !== 1'b0 || out_valid_o !== 1'b0) begin
            $display("load_done_o or out_valid_o not low after reset");
            errors++;
        end
        for (int w = 0; w < GLB_WORDS; w++) begin
            write_glb_word(w, $urandom);
        end

        load_layer(LAYER_CONV, 8);  // aligned base
        run_vector(random_act(), 1'b0, "conv");

        load_layer(LAYER_FC, 3);  // crosses word boundaries
        run_vector(random_act(), 1'b0, "fc");

        load_layer(LAYER_DWCONV, 37);
        for (int c = 0; c < COLS; c++) begin
            act    = '0;
            act[c] = 8'sd1;  // picks column c out of every row
            run_vector(act, 1'b0, "dwconv column");
        end

        act = random_act();
        run_vector(act, 1'b0, "before pool");
        load_layer(LAYER_POOL, 0);  // model stays untouched
        run_vector(act, 1'b0, "after pool");

        run_burst();

        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
